// ==== hw/rv32i_isa_pkg.sv ====
package rv32i_isa_pkg;

  typedef logic [31:0] rv32i_word;
  typedef logic [4:0]  rv32i_reg;

  // Major opcodes, instruction bits [6:0]
  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode;

  typedef enum logic [2:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // Stores reuse lb, lh and lw for sb, sh and sw
  typedef enum logic [2:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

endpackage

// ==== hw/ex_ctrl_pkg.sv ====
package ex_ctrl_pkg;

  typedef enum logic [2:0] {
    alu_add = 3'b000,
    alu_sll = 3'b001,
    alu_sra = 3'b010,
    alu_sub = 3'b011,
    alu_xor = 3'b100,
    alu_srl = 3'b101,
    alu_or  = 3'b110,
    alu_and = 3'b111
  } alu_ops;

  // Second comparator operand
  typedef enum logic {
    cmp_rs2 = 1'b0,
    cmp_imm = 1'b1
  } cmp_sel_t;

  typedef enum logic [1:0] {
    pc_plus4 = 2'b00,
    alu_out  = 2'b01,  // Branch target
    alu_mod2 = 2'b10   // Jalr target, bit 0 cleared
  } pcmux_sel_t;

  typedef enum logic [1:0] {
    fwd_none   = 2'b00,
    fwd_mem_wb = 2'b01,
    fwd_ex_mem = 2'b10
  } fwd_sel_t;

  localparam int BHT_ENTRIES = 16;
  localparam int BHT_IDX_W   = 4;
  localparam int DMEM_WORDS  = 64;
  localparam int DMEM_AW     = 6;

endpackage

// ==== hw/alu.sv ====
`timescale 1ns/1ps

module alu import rv32i_isa_pkg::*, ex_ctrl_pkg::*; (
  input  alu_ops    aluop_i,
  input  rv32i_word a_i,
  input  rv32i_word b_i,
  output rv32i_word f_o,
  output rv32i_word target_o
);

  rv32i_word sum;
  logic [4:0] shamt;

  assign sum   = a_i + b_i;
  assign shamt = b_i[4:0];  // Only low five bits shift

  always_comb begin
    unique case (aluop_i)
      alu_add: f_o = sum;
      alu_sll: f_o = a_i << shamt;
      alu_sra: f_o = rv32i_word'($signed(a_i) >>> shamt);
      alu_sub: f_o = a_i - b_i;
      alu_xor: f_o = a_i ^ b_i;
      alu_srl: f_o = a_i >> shamt;
      alu_or:  f_o = a_i | b_i;
      alu_and: f_o = a_i & b_i;
    endcase
  end

  // Jump target for jalr, also used for branches
  assign target_o = {sum[31:1], 1'b0};

endmodule

// ==== hw/cmp.sv ====
`timescale 1ns/1ps

module cmp import rv32i_isa_pkg::*; (
  input  branch_funct3_t cmpop_i,
  input  rv32i_word      a_i,
  input  rv32i_word      b_i,
  output logic           br_en_o
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    case (cmpop_i)
      beq:     br_en_o = eq;
      bne:     br_en_o = !eq;
      blt:     br_en_o = lt_s;
      bge:     br_en_o = !lt_s;
      bltu:    br_en_o = lt_u;
      bgeu:    br_en_o = !lt_u;
      default: br_en_o = 1'b0;  // Not a branch condition
    endcase
  end

endmodule

// ==== hw/ex_forward_unit.sv ====
`timescale 1ns/1ps

module ex_forward_unit import rv32i_isa_pkg::*, ex_ctrl_pkg::*; (
  input  rv32i_word id_instr_i,
  input  rv32i_reg  ex_mem_rd_i,
  input  logic      ex_mem_load_regfile_i,
  input  logic      ex_mem_is_load_i,
  input  rv32i_reg  mem_wb_rd_i,
  input  logic      mem_wb_load_regfile_i,
  output fwd_sel_t  fwd_a_o,
  output fwd_sel_t  fwd_b_o,
  output fwd_sel_t  fwd_rs2_o
);

  rv32i_reg rs1;
  rv32i_reg rs2;

  assign rs1 = id_instr_i[19:15];
  assign rs2 = id_instr_i[24:20];

  // Newest producer wins, x0 is never forwarded
  function automatic fwd_sel_t pick_source(
    input rv32i_reg src,
    input rv32i_reg exm_rd,
    input logic     exm_wr,
    input logic     exm_load,
    input rv32i_reg mwb_rd,
    input logic     mwb_wr
  );
    fwd_sel_t sel;
    sel = fwd_none;
    if (src != 5'd0) begin
      if (exm_wr && !exm_load && exm_rd == src)
        sel = fwd_ex_mem;  // Load data not ready yet in EX/MEM
      else if (mwb_wr && mwb_rd == src)
        sel = fwd_mem_wb;
    end
    return sel;
  endfunction

  always_comb begin
    fwd_a_o = pick_source(rs1, ex_mem_rd_i, ex_mem_load_regfile_i, ex_mem_is_load_i,
                          mem_wb_rd_i, mem_wb_load_regfile_i);
    fwd_b_o = pick_source(rs2, ex_mem_rd_i, ex_mem_load_regfile_i, ex_mem_is_load_i,
                          mem_wb_rd_i, mem_wb_load_regfile_i);
    // Same rule for compare and store data
    fwd_rs2_o = fwd_b_o;
  end

  // EX/MEM is only a source when it writes a register
  always_comb begin
    if (!ex_mem_load_regfile_i) begin
      assert #0 (fwd_a_o != fwd_ex_mem && fwd_b_o != fwd_ex_mem && fwd_rs2_o != fwd_ex_mem)
        else $error("EX/MEM forward selected without a register write");
    end
  end

endmodule

// ==== hw/instruction_execute.sv ====
`timescale 1ns/1ps

module instruction_execute import rv32i_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  rv32i_word      pc_i,
  input  rv32i_word      instruction_i,
  input  rv32i_word      rs1_data_i,
  input  rv32i_word      rs2_data_i,
  input  rv32i_word      imm_i,
  input  rv32i_opcode    opcode_i,
  input  alu_ops         aluop_i,
  input  branch_funct3_t cmpop_i,
  input  logic           alumux1_pc_i,
  input  logic           alumux2_rs2_i,
  input  logic           cmpmux_imm_i,
  input  pcmux_sel_t     pcmux_sel_i,
  input  logic           load_regfile_i,
  input  logic           ma_stall_i,
  input  logic           pred_i,
  input  rv32i_reg       mem_wb_rd_i,
  input  logic           mem_wb_load_regfile_i,
  input  rv32i_word      mem_wb_data_i,
  output logic           br_miss_o,
  output pcmux_sel_t     pcmux_sel_o,
  output rv32i_word      alu_out_to_pc_o,
  output logic           pred_update_o,
  output logic           pred_taken_o,
  output rv32i_word      ex_alu_out_o,
  output rv32i_word      ex_rs2_o,
  output rv32i_reg       ex_rd_o,
  output logic [2:0]     ex_funct3_o,
  output logic           ex_load_regfile_o,
  output logic           ex_is_load_o,
  output logic           ex_is_store_o,
  output logic [3:0]     ex_mem_byte_enable_o,
  output logic [1:0]     ex_addr_offset_o,
  output rv32i_word      ex_pc_o
);

  fwd_sel_t   fwd_a, fwd_b, fwd_rs2;
  cmp_sel_t   cmp_sel;
  rv32i_word  rs1_fwd, rs2_alu_fwd, rs2_fwd;
  rv32i_word  alu_a, alu_b, cmp_b;
  rv32i_word  alu_f, alu_target;
  logic       br_en;
  logic       is_mem_op;
  logic [3:0] byte_enable;

  function automatic rv32i_word fwd_mux(
    input fwd_sel_t  sel,
    input rv32i_word reg_val,
    input rv32i_word mem_wb_val,
    input rv32i_word ex_mem_val
  );
    case (sel)
      fwd_mem_wb: return mem_wb_val;
      fwd_ex_mem: return ex_mem_val;
      default:    return reg_val;
    endcase
  endfunction

  ex_forward_unit efu0 (
    .id_instr_i            (instruction_i),
    .ex_mem_rd_i           (ex_rd_o),
    .ex_mem_load_regfile_i (ex_load_regfile_o),
    .ex_mem_is_load_i      (ex_is_load_o),
    .mem_wb_rd_i           (mem_wb_rd_i),
    .mem_wb_load_regfile_i (mem_wb_load_regfile_i),
    .fwd_a_o               (fwd_a),
    .fwd_b_o               (fwd_b),
    .fwd_rs2_o             (fwd_rs2)
  );

  always_comb begin
    rs1_fwd     = fwd_mux(fwd_a, rs1_data_i, mem_wb_data_i, ex_alu_out_o);
    rs2_alu_fwd = fwd_mux(fwd_b, rs2_data_i, mem_wb_data_i, ex_alu_out_o);
    rs2_fwd     = fwd_mux(fwd_rs2, rs2_data_i, mem_wb_data_i, ex_alu_out_o);
  end

  assign cmp_sel = cmp_sel_t'(cmpmux_imm_i);
  assign alu_a   = alumux1_pc_i ? pc_i : rs1_fwd;          // PC only for auipc, jal, branches
  assign alu_b   = alumux2_rs2_i ? rs2_alu_fwd : imm_i;
  assign cmp_b   = (cmp_sel == cmp_imm) ? imm_i : rs2_fwd;

  alu alu0 (
    .aluop_i  (aluop_i),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .f_o      (alu_f),
    .target_o (alu_target)
  );

  cmp cmp0 (
    .cmpop_i (cmpop_i),
    .a_i     (rs1_fwd),
    .b_i     (cmp_b),
    .br_en_o (br_en)
  );

  // Resolve against the prediction
  always_comb begin
    alu_out_to_pc_o = alu_target;
    if (opcode_i == op_jal || opcode_i == op_jalr) begin
      br_miss_o   = 1'b1;
      pcmux_sel_o = pcmux_sel_i;
    end else if (opcode_i == op_br && br_en != pred_i) begin
      br_miss_o       = 1'b1;
      pcmux_sel_o     = pcmux_sel_i;
      alu_out_to_pc_o = pred_i ? (pc_i + 32'd4) : alu_target;  // Undo a wrong taken guess
    end else begin
      br_miss_o   = 1'b0;
      pcmux_sel_o = pc_plus4;
    end
  end

  assign pred_update_o = (opcode_i == op_br);
  assign pred_taken_o  = br_en;

  assign is_mem_op = (opcode_i == op_load || opcode_i == op_store);

  always_comb begin
    byte_enable = 4'b0000;
    if (is_mem_op) begin
      case (load_funct3_t'(instruction_i[14:12]))
        lw:       byte_enable = 4'b1111 << alu_f[1:0];
        lh, lhu:  byte_enable = 4'b0011 << alu_f[1:0];
        lb, lbu:  byte_enable = 4'b0001 << alu_f[1:0];
        default:  byte_enable = 4'b0000;
      endcase
    end
  end

  // EX/MEM register, frozen by a memory stall
  always_ff @(posedge clk) begin
    if (rst) begin
      ex_alu_out_o         <= '0;
      ex_rs2_o             <= '0;
      ex_rd_o              <= '0;
      ex_funct3_o          <= '0;
      ex_load_regfile_o    <= 1'b0;
      ex_is_load_o         <= 1'b0;
      ex_is_store_o        <= 1'b0;
      ex_mem_byte_enable_o <= '0;
      ex_addr_offset_o     <= '0;
      ex_pc_o              <= '0;
    end else if (!ma_stall_i) begin
      ex_alu_out_o         <= alu_f;
      ex_rs2_o             <= rs2_fwd;  // Store data
      ex_rd_o              <= instruction_i[11:7];
      ex_funct3_o          <= instruction_i[14:12];
      ex_load_regfile_o    <= load_regfile_i;
      ex_is_load_o         <= (opcode_i == op_load);
      ex_is_store_o        <= (opcode_i == op_store);
      ex_mem_byte_enable_o <= byte_enable;
      ex_addr_offset_o     <= alu_f[1:0];
      ex_pc_o              <= pc_i;
    end
  end

  a_miss_only_on_flow: assert property (@(posedge clk) disable iff (rst)
    br_miss_o |-> opcode_i inside {op_br, op_jal, op_jalr})
    else $error("Redirect raised for opcode %b", opcode_i);

  a_be_only_mem: assert property (@(posedge clk) disable iff (rst)
    (byte_enable != 4'b0000) |-> is_mem_op)
    else $error("Byte enable %b outside a load or store", byte_enable);

endmodule

// ==== hw/branch_history_table.sv ====
`timescale 1ns/1ps

module branch_history_table import rv32i_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  rv32i_word rd_pc_i,
  output logic      pred_o,
  input  logic      upd_i,
  input  logic      upd_taken_i
);

  logic [1:0] counters [BHT_ENTRIES];
  logic [BHT_IDX_W-1:0] idx;
  logic [1:0] cur;

  assign idx    = rd_pc_i[BHT_IDX_W+1:2];  // Word-aligned PC
  assign cur    = counters[idx];
  assign pred_o = cur[1];                  // 2 or 3 means taken

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < BHT_ENTRIES; i++) begin
        counters[i] <= 2'b01;  // Weakly not taken
      end
    end else if (upd_i) begin
      // Saturate at both ends
      if (upd_taken_i && cur != 2'b11)
        counters[idx] <= cur + 2'b01;
      else if (!upd_taken_i && cur != 2'b00)
        counters[idx] <= cur - 2'b01;
    end
  end

endmodule

// ==== hw/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage import rv32i_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       ma_stall_i,
  input  rv32i_word  ex_alu_out_i,
  input  rv32i_word  ex_rs2_i,
  input  rv32i_reg   ex_rd_i,
  input  logic [2:0] ex_funct3_i,
  input  logic       ex_load_regfile_i,
  input  logic       ex_is_load_i,
  input  logic       ex_is_store_i,
  input  logic [3:0] ex_mem_byte_enable_i,
  input  logic [1:0] ex_addr_offset_i,
  input  rv32i_word  ex_pc_i,
  output logic       wb_valid_o,
  output rv32i_reg   wb_rd_o,
  output rv32i_word  wb_data_o
);

  rv32i_word dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0] word_addr;
  logic [4:0] bit_shift;
  rv32i_word wr_data, rd_word, rd_shifted, load_data;

  assign word_addr  = ex_alu_out_i[DMEM_AW+1:2];
  assign bit_shift  = {ex_addr_offset_i, 3'b000};
  assign wr_data    = ex_rs2_i << bit_shift;  // Align store lanes with byte enables
  assign rd_word    = dmem[word_addr];
  assign rd_shifted = rd_word >> bit_shift;

  always_comb begin
    case (load_funct3_t'(ex_funct3_i))
      lb:      load_data = {{24{rd_shifted[7]}}, rd_shifted[7:0]};
      lbu:     load_data = {24'd0, rd_shifted[7:0]};
      lh:      load_data = {{16{rd_shifted[15]}}, rd_shifted[15:0]};
      lhu:     load_data = {16'd0, rd_shifted[15:0]};
      default: load_data = rd_shifted;  // lw
    endcase
  end

  always_ff @(posedge clk) begin
    if (!ma_stall_i && ex_is_store_i) begin
      for (int b = 0; b < 4; b++) begin
        if (ex_mem_byte_enable_i[b])
          dmem[word_addr][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  // MEM/WB register, also the forwarding source
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid_o <= 1'b0;
      wb_rd_o    <= '0;
      wb_data_o  <= '0;
    end else if (!ma_stall_i) begin
      wb_valid_o <= ex_load_regfile_i;
      wb_rd_o    <= ex_rd_i;
      wb_data_o  <= ex_is_load_i ? load_data : ex_alu_out_i;
    end
  end

  // Execute must hand over at least one lane for every access
  a_access_has_lanes: assert property (@(posedge clk) disable iff (rst)
    (ex_is_load_i || ex_is_store_i) |-> (ex_mem_byte_enable_i != 4'b0000))
    else $error("Memory access without byte enables, pc %h", ex_pc_i);

endmodule

// ==== hw/ex_stage_top.sv ====
`timescale 1ns/1ps

module ex_stage_top import rv32i_isa_pkg::*, ex_ctrl_pkg::*; (
  input  logic           clk,
  input  logic           rst,
  input  rv32i_word      pc_i,
  input  rv32i_word      instruction_i,
  input  rv32i_word      rs1_data_i,
  input  rv32i_word      rs2_data_i,
  input  rv32i_word      imm_i,
  input  rv32i_opcode    opcode_i,
  input  alu_ops         aluop_i,
  input  branch_funct3_t cmpop_i,
  input  logic           alumux1_pc_i,
  input  logic           alumux2_rs2_i,
  input  logic           cmpmux_imm_i,
  input  pcmux_sel_t     pcmux_sel_i,
  input  logic           load_regfile_i,
  input  logic           ma_stall_i,
  output logic           br_miss_o,
  output pcmux_sel_t     pcmux_sel_o,
  output rv32i_word      alu_out_to_pc_o,
  output logic           wb_valid_o,
  output rv32i_reg       wb_rd_o,
  output rv32i_word      wb_data_o
);

  logic       pred, pred_update, pred_taken;
  rv32i_word  ex_alu_out, ex_rs2, ex_pc;
  rv32i_reg   ex_rd;
  logic [2:0] ex_funct3;
  logic       ex_load_regfile, ex_is_load, ex_is_store;
  logic [3:0] ex_mem_byte_enable;
  logic [1:0] ex_addr_offset;

  branch_history_table bht0 (
    .clk         (clk),
    .rst         (rst),
    .rd_pc_i     (pc_i),
    .pred_o      (pred),
    .upd_i       (pred_update),
    .upd_taken_i (pred_taken)
  );

  instruction_execute ex0 (
    .clk                   (clk),
    .rst                   (rst),
    .pc_i                  (pc_i),
    .instruction_i         (instruction_i),
    .rs1_data_i            (rs1_data_i),
    .rs2_data_i            (rs2_data_i),
    .imm_i                 (imm_i),
    .opcode_i              (opcode_i),
    .aluop_i               (aluop_i),
    .cmpop_i               (cmpop_i),
    .alumux1_pc_i          (alumux1_pc_i),
    .alumux2_rs2_i         (alumux2_rs2_i),
    .cmpmux_imm_i          (cmpmux_imm_i),
    .pcmux_sel_i           (pcmux_sel_i),
    .load_regfile_i        (load_regfile_i),
    .ma_stall_i            (ma_stall_i),
    .pred_i                (pred),
    .mem_wb_rd_i           (wb_rd_o),
    .mem_wb_load_regfile_i (wb_valid_o),  // Valid WB means a register write
    .mem_wb_data_i         (wb_data_o),
    .br_miss_o             (br_miss_o),
    .pcmux_sel_o           (pcmux_sel_o),
    .alu_out_to_pc_o       (alu_out_to_pc_o),
    .pred_update_o         (pred_update),
    .pred_taken_o          (pred_taken),
    .ex_alu_out_o          (ex_alu_out),
    .ex_rs2_o              (ex_rs2),
    .ex_rd_o               (ex_rd),
    .ex_funct3_o           (ex_funct3),
    .ex_load_regfile_o     (ex_load_regfile),
    .ex_is_load_o          (ex_is_load),
    .ex_is_store_o         (ex_is_store),
    .ex_mem_byte_enable_o  (ex_mem_byte_enable),
    .ex_addr_offset_o      (ex_addr_offset),
    .ex_pc_o               (ex_pc)
  );

  mem_stage mem0 (
    .clk                  (clk),
    .rst                  (rst),
    .ma_stall_i           (ma_stall_i),
    .ex_alu_out_i         (ex_alu_out),
    .ex_rs2_i             (ex_rs2),
    .ex_rd_i              (ex_rd),
    .ex_funct3_i          (ex_funct3),
    .ex_load_regfile_i    (ex_load_regfile),
    .ex_is_load_i         (ex_is_load),
    .ex_is_store_i        (ex_is_store),
    .ex_mem_byte_enable_i (ex_mem_byte_enable),
    .ex_addr_offset_i     (ex_addr_offset),
    .ex_pc_i              (ex_pc),
    .wb_valid_o           (wb_valid_o),
    .wb_rd_o              (wb_rd_o),
    .wb_data_o            (wb_data_o)
  );

endmodule

// ==== verification/tb_ex_stage.sv ====
`timescale 1ns/1ps

module tb_ex_stage import rv32i_isa_pkg::*, ex_ctrl_pkg::*; ();

  localparam int NUM_INSTR    = 2000;
  localparam int LIMIT_CYCLES = (NUM_INSTR + DMEM_WORDS) * 2 + 50;

  logic clk, rst;
  rv32i_word pc_i, instruction_i, rs1_data_i, rs2_data_i, imm_i;
  rv32i_opcode opcode_i;
  alu_ops aluop_i;
  branch_funct3_t cmpop_i;
  logic alumux1_pc_i, alumux2_rs2_i, cmpmux_imm_i, load_regfile_i, ma_stall_i;
  pcmux_sel_t pcmux_sel_i;
  logic br_miss_o, wb_valid_o;
  pcmux_sel_t pcmux_sel_o;
  rv32i_word alu_out_to_pc_o, wb_data_o;
  rv32i_reg wb_rd_o;

  // Current instruction as decoded fields
  rv32i_word cur_pc, cur_imm, cur_res, cur_sum;
  rv32i_reg cur_rs1, cur_rs2, cur_rd, last_load_rd;
  logic [2:0] cur_f3;
  rv32i_opcode cur_opc;
  alu_ops cur_aop;
  branch_funct3_t cur_cop;
  logic cur_mux1, cur_mux2, cur_cimm, cur_ldreg, cur_br_en;
  pcmux_sel_t cur_psel;

  // Model state
  rv32i_word arch [8];  // Newest values
  rv32i_word rf [8];    // Values already written back
  rv32i_word mem_model [DMEM_WORDS];
  logic [1:0] bht [BHT_ENTRIES];
  logic exm_v, mwb_v;
  rv32i_reg exm_rd, mwb_rd;
  rv32i_word exm_d, mwb_d;

  branch_funct3_t conds [6] = '{beq, bne, blt, bge, bltu, bgeu};
  load_funct3_t lfuncs [5] = '{lb, lh, lw, lbu, lhu};

  ex_stage_top dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    $display("Timeout: the instruction stream did not finish in time");
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  task automatic check_value(input string name, input rv32i_word got, input rv32i_word exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic rv32i_word alu_model(input alu_ops op, input rv32i_word a,
                                          input rv32i_word b);
    case (op)
      alu_add: return a + b;
      alu_sll: return a << b[4:0];
      alu_sra: return rv32i_word'($signed(a) >>> b[4:0]);
      alu_sub: return a - b;
      alu_xor: return a ^ b;
      alu_srl: return a >> b[4:0];
      alu_or:  return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input branch_funct3_t c, input rv32i_word a,
                                        input rv32i_word b);
    case (c)
      beq:     return a == b;
      bne:     return a != b;
      blt:     return $signed(a) < $signed(b);
      bge:     return $signed(a) >= $signed(b);
      bltu:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  function automatic rv32i_word load_extend(input logic [2:0] f3, input rv32i_word word,
                                            input logic [1:0] off);
    rv32i_word w;
    w = word >> {off, 3'b000};
    case (f3)
      3'b000:  return {{24{w[7]}}, w[7:0]};
      3'b100:  return {24'd0, w[7:0]};
      3'b001:  return {{16{w[15]}}, w[15:0]};
      3'b101:  return {16'd0, w[15:0]};
      default: return w;
    endcase
  endfunction

  function automatic rv32i_word fill_word(input int a);
    return (32'(a) * 32'h0104_1041) ^ 32'h5a3c_96e1;  // Differs for every word
  endfunction

  // Works out the current result and updates model memory and registers in order
  task automatic compute_result();
    rv32i_word a, b, sdata;
    logic [3:0] mask, be;
    logic [1:0] off;
    logic [DMEM_AW-1:0] w;
    a = cur_mux1 ? cur_pc : arch[cur_rs1];
    b = cur_mux2 ? arch[cur_rs2] : cur_imm;
    cur_sum = a + b;
    cur_res = alu_model(cur_aop, a, b);
    cur_br_en = branch_taken(cur_cop, arch[cur_rs1], cur_cimm ? cur_imm : arch[cur_rs2]);
    if (cur_opc == op_load || cur_opc == op_store) begin
      off = cur_res[1:0];
      w = cur_res[DMEM_AW+1:2];
      if (cur_f3[1:0] == 2'b10) mask = 4'b1111;
      else if (cur_f3[1:0] == 2'b01) mask = 4'b0011;
      else mask = 4'b0001;
      be = mask << off;
      if (cur_opc == op_store) begin
        sdata = arch[cur_rs2] << {off, 3'b000};
        for (int i = 0; i < 4; i++) begin
          if (be[i]) mem_model[w][8*i +: 8] = sdata[8*i +: 8];
        end
      end else begin
        cur_res = load_extend(cur_f3, mem_model[w], off);
      end
    end
    if (cur_ldreg && cur_rd != 5'd0) arch[cur_rd] = cur_res;
  endtask

  task automatic set_bubble();
    cur_pc = '0;
    cur_imm = '0;
    cur_rs1 = '0;
    cur_rs2 = '0;
    cur_rd = '0;
    cur_f3 = 3'b000;
    cur_opc = op_imm;
    cur_aop = alu_add;
    cur_cop = beq;
    cur_mux1 = 1'b0;
    cur_mux2 = 1'b0;
    cur_cimm = 1'b0;
    cur_ldreg = 1'b0;
    cur_psel = pc_plus4;
  endtask

  task automatic make_instr();
    int kind;
    set_bubble();
    cur_pc  = $urandom & 32'hffff_fffc;
    cur_imm = $urandom;
    cur_rd  = 5'($urandom % 8);
    cur_cop = conds[$urandom % 6];
    cur_f3  = cur_cop;
    // No reader of a load result in the very next slot
    do cur_rs1 = 5'($urandom % 8); while (last_load_rd != 0 && cur_rs1 == last_load_rd);
    do cur_rs2 = 5'($urandom % 8); while (last_load_rd != 0 && cur_rs2 == last_load_rd);
    kind = $urandom % 8;
    case (kind)
      0, 1: begin
        cur_opc = op_reg;
        cur_aop = alu_ops'($urandom % 8);
        cur_mux2 = 1'b1;
        cur_ldreg = 1'b1;
      end
      2: begin
        cur_opc = op_auipc;
        cur_mux1 = 1'b1;
        cur_ldreg = 1'b1;
      end
      3: begin
        cur_opc = op_imm;
        cur_aop = alu_ops'($urandom % 8);
        cur_ldreg = 1'b1;
      end
      4: begin
        cur_opc = op_br;
        cur_mux1 = 1'b1;
        cur_psel = alu_out;
        cur_cimm = ($urandom % 4 == 0);
      end
      5: begin
        if ($urandom % 2 == 0) begin
          cur_opc = op_jal;
          cur_mux1 = 1'b1;
          cur_psel = alu_out;
        end else begin
          cur_opc = op_jalr;
          cur_psel = alu_mod2;
        end
      end
      6: begin
        cur_opc = op_load;
        cur_f3 = lfuncs[$urandom % 5];
        cur_ldreg = 1'b1;
        cur_imm = ($urandom % 256) - arch[cur_rs1];
      end
      default: begin
        cur_opc = op_store;
        cur_f3 = lfuncs[$urandom % 3];
        cur_imm = ($urandom % 256) - arch[cur_rs1];
      end
    endcase
    last_load_rd = (cur_opc == op_load) ? cur_rd : 5'd0;
  endtask

  // One clock cycle starting 2 ns after a rising edge
  task automatic cycle_step(input logic stall);
    logic exp_pred, exp_miss;
    pcmux_sel_t exp_sel;
    rv32i_word exp_tgt;
    logic [BHT_IDX_W-1:0] idx;
    pc_i = cur_pc;
    instruction_i = {7'd0, cur_rs2, cur_rs1, cur_f3, cur_rd, cur_opc};
    rs1_data_i = rf[cur_rs1];
    rs2_data_i = rf[cur_rs2];
    imm_i = cur_imm;
    opcode_i = cur_opc;
    aluop_i = cur_aop;
    cmpop_i = cur_cop;
    alumux1_pc_i = cur_mux1;
    alumux2_rs2_i = cur_mux2;
    cmpmux_imm_i = cur_cimm;
    pcmux_sel_i = cur_psel;
    load_regfile_i = cur_ldreg;
    ma_stall_i = stall;
    #8;
    idx = cur_pc[BHT_IDX_W+1:2];
    exp_pred = bht[idx][1];
    exp_tgt = {cur_sum[31:1], 1'b0};
    exp_miss = 1'b0;
    exp_sel = pc_plus4;
    if (cur_opc == op_jal || cur_opc == op_jalr) begin
      exp_miss = 1'b1;
      exp_sel = cur_psel;
    end else if (cur_opc == op_br && cur_br_en != exp_pred) begin
      exp_miss = 1'b1;
      exp_sel = cur_psel;
      if (exp_pred) exp_tgt = cur_pc + 32'd4;
    end
    check_value("br_miss_o", 32'(br_miss_o), 32'(exp_miss));
    check_value("pcmux_sel_o", 32'(pcmux_sel_o), 32'(exp_sel));
    check_value("alu_out_to_pc_o", alu_out_to_pc_o, exp_tgt);
    check_value("wb_valid_o", 32'(wb_valid_o), 32'(mwb_v));
    check_value("wb_rd_o", 32'(wb_rd_o), 32'(mwb_rd));
    check_value("wb_data_o", wb_data_o, mwb_d);
    // Table updates in every cycle a branch sits in EX even when stalled
    if (cur_opc == op_br) begin
      if (cur_br_en && bht[idx] != 2'b11) bht[idx] = bht[idx] + 2'b01;
      else if (!cur_br_en && bht[idx] != 2'b00) bht[idx] = bht[idx] - 2'b01;
    end
    if (!stall) begin
      if (mwb_v && mwb_rd != 5'd0) rf[mwb_rd] = mwb_d;
      mwb_v = exm_v;
      mwb_rd = exm_rd;
      mwb_d = exm_d;
      exm_v = cur_ldreg;
      exm_rd = cur_rd;
      exm_d = cur_res;
    end
    @(posedge clk);
    #2;
  endtask

  initial begin
    int stalls;
    void'($urandom(32'hfbdd));
    last_load_rd = '0;
    exm_v = 1'b0;
    exm_rd = '0;
    exm_d = '0;
    mwb_v = 1'b0;
    mwb_rd = '0;
    mwb_d = '0;
    for (int i = 0; i < 8; i++) begin
      arch[i] = '0;
      rf[i] = '0;
    end
    for (int i = 0; i < BHT_ENTRIES; i++) bht[i] = 2'b01;
    set_bubble();
    pc_i = '0;
    instruction_i = '0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    imm_i = '0;
    opcode_i = op_imm;
    aluop_i = alu_add;
    cmpop_i = beq;
    pcmux_sel_i = pc_plus4;
    alumux1_pc_i = 1'b0;
    alumux2_rs2_i = 1'b0;
    cmpmux_imm_i = 1'b0;
    load_regfile_i = 1'b0;
    ma_stall_i = 1'b0;
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    check_value("wb_valid_o", 32'(wb_valid_o), 32'd0);

    // Fill the whole data RAM with word stores through x1
    for (int a = 0; a < DMEM_WORDS; a++) begin
      set_bubble();
      cur_opc = op_store;
      cur_f3 = 3'b010;
      cur_rs2 = 5'd1;
      cur_imm = 32'(a * 4);
      cur_pc = 32'(a * 4);
      arch[1] = fill_word(a);
      rf[1] = arch[1];
      compute_result();
      cycle_step(1'b0);
    end
    for (int i = 1; i < 8; i++) begin
      arch[i] = $urandom;
      rf[i] = arch[i];
    end

    for (int n = 0; n < NUM_INSTR; n++) begin
      make_instr();
      compute_result();
      stalls = ($urandom % 8 == 0) ? 1 + $urandom % 2 : 0;
      for (int s = 0; s < stalls; s++) cycle_step(1'b1);
      cycle_step(1'b0);
    end
    set_bubble();
    compute_result();
    repeat (2) cycle_step(1'b0);  // Drain the last two results

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== sim.f ====
hw/rv32i_isa_pkg.sv
hw/ex_ctrl_pkg.sv
hw/alu.sv
hw/cmp.sv
hw/ex_forward_unit.sv
hw/instruction_execute.sv
hw/branch_history_table.sv
hw/mem_stage.sv
hw/ex_stage_top.sv
verification/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_ex_stage
FILELIST  := sim.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
